//--- fsqrt.f
+incdir+sim
logic/fsqrt_pkg.sv
logic/fp_sqrt_unpack.sv
logic/isqrt_iter.sv
logic/fp_sqrt_round.sv
logic/fsqrt.sv
sim/tb_fsqrt.sv

//--- logic/fp_sqrt_round.sv
/* sqrt rounding and packing
   rounds the core root by mode, bumps the exponent on carry, flags inexact */
`default_nettype none

module fp_sqrt_round import fsqrt_pkg::*; (
  input  wire [root_w-1:0]  root,
  input  wire               rem_nz,
  input  wire [exp_w-1:0]   half_exp,
  input  wire [2:0]         frm,
  output logic [31:0]       z,
  output logic              inexact
);

  logic [man_w:0]   sig;       // 24 bits, leading one at top
  logic             guard;
  logic             rnd;
  logic             sticky;
  logic [2:0]       mode;
  logic             inc;
  logic [man_w+1:0] sig_inc;
  logic [exp_w-1:0] exp_out;

  assign sig    = root[root_w-1 -: man_w+1];
  assign guard  = root[1];
  assign rnd    = root[0];
  assign sticky = rem_nz;

  // reserved codes 5..7 fall back to nearest-even
  assign mode = (frm > rm_rmm) ? rm_rne : frm;

  // result is always positive so down truncates and up rounds away
  always_comb begin
    case (mode)
      rm_rne:         inc = guard & (rnd | sticky | sig[0]);
      rm_rtz, rm_rdn: inc = 1'b0;
      rm_rup:         inc = guard | rnd | sticky;
      rm_rmm:         inc = guard;
      default:        inc = 1'b0;
    endcase
  end

  assign sig_inc = {1'b0, sig} + {{(man_w + 1){1'b0}}, inc};

  // carry out leaves an all-zero fraction, only the exponent moves
  assign exp_out = half_exp + {{(exp_w - 1){1'b0}}, sig_inc[man_w+1]};

  assign z       = {1'b0, exp_out, sig_inc[man_w-1:0]};
  assign inexact = guard | rnd | sticky;

endmodule

`default_nettype wire

//--- logic/fp_sqrt_unpack.sv
/* sqrt operand unpacker
   classifies the operand, normalises denormals and builds the core radicand */
`default_nettype none

module fp_sqrt_unpack import fsqrt_pkg::*; (
  input  wire [31:0]     a,
  output sqrt_operand_t  opnd
);

  logic             sign;
  logic [exp_w-1:0] exp_f;
  logic [man_w-1:0] frac;
  logic [exp_w-1:0] exp_eff;
  logic [man_w:0]   sig;        // with hidden bit
  logic [4:0]       lz;
  logic [man_w:0]   sig_norm;
  logic [9:0]       exp_unb;    // two's complement
  logic [9:0]       half_b;
  logic [man_w+1:0] sig_even;

  assign sign  = a[31];
  assign exp_f = a[30:23];
  assign frac  = a[22:0];

  // denormals use exponent 1 with no hidden bit
  assign exp_eff = (exp_f == '0) ? 8'd1 : exp_f;
  assign sig     = {exp_f != '0, frac};

  // leading zero count, highest set bit wins
  always_comb begin
    lz = '0;
    for (int i = 0; i <= man_w; i++) begin
      if (sig[i]) lz = 5'(man_w - i);
    end
  end

  assign sig_norm = sig << lz;
  assign exp_unb  = {2'b00, exp_eff} - 10'(exp_bias) - {5'b0, lz};

  // odd exponent: one more place left, remaining exponent is even
  assign sig_even = exp_unb[0] ? {sig_norm, 1'b0} : {1'b0, sig_norm};

  // arithmetic halving rounds odd exponents down, matching the shift above
  assign half_b = {exp_unb[9], exp_unb[9:1]} + 10'(exp_bias);

  always_comb begin
    opnd.sign     = sign;
    opnd.half_exp = half_b[exp_w-1:0];
    opnd.radicand = {sig_even, {(rad_w - man_w - 2){1'b0}}};  // root msb lands on top
    if (exp_f == '1 && frac != '0) begin
      opnd.cls = nan_in;
    end else if (exp_f == '0 && frac == '0) begin
      opnd.cls = zero;
    end else if (sign) begin
      opnd.cls = invalid_neg;
    end else if (exp_f == '1) begin
      opnd.cls = pos_inf;
    end else begin
      opnd.cls = normal;
    end
  end

endmodule

`default_nettype wire

//--- logic/fsqrt.sv
/* single-precision square root, top level
   captures operand and mode, resolves special operands directly and runs
   the iterative core for finite positive ones */
`default_nettype none

module fsqrt import fsqrt_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire          in_stb,
  input  wire [31:0]   input_a,
  input  wire [2:0]    frm,
  output logic         busy,
  output logic [31:0]  output_z,
  output logic         output_z_stb,
  output flag_t        fflags
);

  typedef enum logic [1:0] {
    idle,
    classify,   // operand unpacked this edge
    run,        // core start
    finish      // special result or wait for done
  } state_t;

  state_t          state;
  logic [31:0]     a_q;
  logic [2:0]      frm_q;
  sqrt_operand_t   opnd;
  sqrt_operand_t   opnd_q;
  logic            start;
  logic            done;
  logic [root_w-1:0] root;
  logic            rem_nz;
  logic [31:0]     rnd_z;
  logic            rnd_inexact;
  logic [31:0]     res_z;
  flag_t           res_flags;
  logic            accept;
  logic            finish_now;

  assign accept     = (state == idle) && in_stb;
  assign finish_now = (state == finish) && (opnd_q.cls != normal || done);

  fp_sqrt_unpack i_unpack (
    .a    (a_q),
    .opnd (opnd)
  );

  isqrt_iter #(
    .width (root_w)
  ) i_core (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .rad    (opnd_q.radicand),
    .done   (done),
    .root   (root),
    .rem_nz (rem_nz)
  );

  fp_sqrt_round i_round (
    .root     (root),
    .rem_nz   (rem_nz),
    .half_exp (opnd_q.half_exp),
    .frm      (frm_q),
    .z        (rnd_z),
    .inexact  (rnd_inexact)
  );

  // result word by class
  always_comb begin
    res_flags = '0;
    case (opnd_q.cls)
      zero:        res_z = {opnd_q.sign, 31'b0};   // signed zero back
      pos_inf:     res_z = {1'b0, {exp_w{1'b1}}, {man_w{1'b0}}};
      nan_in:      res_z = qnan_bits;
      invalid_neg: begin
        res_z             = qnan_bits;
        res_flags.invalid = 1'b1;
      end
      default: begin
        res_z             = rnd_z;
        res_flags.inexact = rnd_inexact;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= idle;
      busy         <= 1'b0;
      output_z_stb <= 1'b0;
      start        <= 1'b0;
      fflags       <= '0;
    end else begin
      output_z_stb <= 1'b0;
      start        <= 1'b0;
      case (state)
        idle: begin
          if (in_stb) begin
            busy  <= 1'b1;
            state <= classify;
          end
        end
        classify: state <= (opnd.cls == normal) ? run : finish;
        run: begin
          start <= 1'b1;
          state <= finish;
        end
        finish: begin
          if (finish_now) begin
            output_z_stb <= 1'b1;
            busy         <= 1'b0;    // low in the strobe cycle
            fflags       <= res_flags;
            state        <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // payload regs
  always_ff @(posedge clk) begin
    if (accept) begin
      a_q   <= input_a;
      frm_q <= frm;
    end
    if (state == classify) opnd_q <= opnd;
    if (finish_now) output_z <= res_z;   // held until next result
  end

endmodule

`default_nettype wire

//--- logic/fsqrt_pkg.sv
/* fsqrt package
   float field widths, rounding modes, flags and the unpacked operand type
   shared by the square-root unit */
`default_nettype none

package fsqrt_pkg;

  // single-precision fields
  localparam int exp_w    = 8;
  localparam int man_w    = 23;
  localparam int exp_bias = 127;

  // 24 significand bits + guard + round
  localparam int root_w = 26;
  localparam int rad_w  = 2 * root_w;

  localparam logic [31:0] qnan_bits = 32'h7fc0_0000;  // +, all-ones exp, frac msb

  // risc-v frm encoding
  localparam logic [2:0] rm_rne = 3'd0;
  localparam logic [2:0] rm_rtz = 3'd1;
  localparam logic [2:0] rm_rdn = 3'd2;
  localparam logic [2:0] rm_rup = 3'd3;
  localparam logic [2:0] rm_rmm = 3'd4;

  typedef struct packed {
    logic invalid;
    logic inexact;
  } flag_t;

  // operand classes, only normal goes through the core
  typedef enum logic [2:0] {
    normal,       // finite, positive, nonzero
    zero,         // either sign
    pos_inf,
    nan_in,
    invalid_neg   // negative nonzero incl. -inf
  } op_class_t;

  typedef struct packed {
    op_class_t              cls;
    logic                   sign;
    logic [exp_w-1:0]       half_exp;   // biased result exponent
    logic [rad_w-1:0]       radicand;
  } sqrt_operand_t;

endpackage

`default_nettype wire

//--- logic/isqrt_iter.sv
/* iterative integer square root
   one root bit per clock, digit by digit, done pulse after width cycles */
`default_nettype none

module isqrt_iter import fsqrt_pkg::*; #(
  parameter int width = root_w   // root bits, radicand is twice as wide
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   start,
  input  wire [2*width-1:0]     rad,
  output logic                  done,
  output logic [width-1:0]      root,
  output logic                  rem_nz
);

  logic [2*width-1:0]     x;          // radicand bits still to bring down
  logic [2*width-1:0]     x_cur;
  logic [width-1:0]       q;          // partial root
  logic [width-1:0]       q_cur;
  logic [width-1:0]       q_next;
  logic [width+1:0]       ac;         // partial remainder
  logic [width+1:0]       ac_cur;
  logic [width+1:0]       ac_sh;
  logic [width+1:0]       ac_next;
  logic [width+2:0]       test;       // one extra bit for the sign
  logic                   running;
  logic [$clog2(width)-1:0] cnt;

  // start edge already does the first iteration from fresh values
  always_comb begin
    x_cur  = start ? rad : x;
    q_cur  = start ? '0 : q;
    ac_cur = start ? '0 : ac;
    ac_sh  = {ac_cur[width-1:0], x_cur[2*width-1 -: 2]};  // bring down two bits
    test   = {1'b0, ac_sh} - {1'b0, q_cur, 2'b01};
    if (!test[width+2]) begin
      ac_next = test[width+1:0];
      q_next  = {q_cur[width-2:0], 1'b1};
    end else begin
      ac_next = ac_sh;                 // trial failed, keep remainder
      q_next  = {q_cur[width-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      done    <= 1'b0;
      cnt     <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;             // start mid-run restarts
        cnt     <= 1'b1;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (cnt == width - 1) begin  // last bit this edge
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start || running) begin
      x  <= x_cur << 2;
      q  <= q_next;
      ac <= ac_next;
    end
  end

  // held until the next start
  assign root   = q;
  assign rem_nz = |ac;   // sticky

endmodule

`default_nettype wire

//--- sim/fsqrt_ref.svh
/* square-root reference model
   expected word and flags from the ieee-754 rules, root found by bisection */
`ifndef FSQRT_REF_SVH
`define FSQRT_REF_SVH

typedef struct packed {
  logic [31:0] z;
  flag_t       flags;
  logic        uses_core;   // finite positive operand, long latency
} ref_result_t;

function automatic ref_result_t fsqrt_ref(input logic [31:0] a, input logic [2:0] rm);
  ref_result_t r;
  logic        sign;
  logic [7:0]  e;
  logic [22:0] f;
  logic [24:0] m;
  int          ue;
  int          be;
  logic [63:0] n;
  logic [63:0] lo;
  logic [63:0] hi;
  logic [63:0] mid;
  logic [63:0] rem;
  logic [25:0] rt;
  logic [23:0] sig;
  logic [24:0] sig_r;
  logic        g;
  logic        rb;
  logic        s;
  logic        above;
  logic        tie;
  logic        up;
  logic [2:0]  mode;

  sign = a[31];
  e    = a[30:23];
  f    = a[22:0];
  r    = '0;

  // specials never reach the core
  if (e == 8'hff && f != 0) begin
    r.z = 32'h7fc0_0000;
    return r;
  end
  if (e == 8'h00 && f == 0) begin
    r.z = a;               // signed zero back
    return r;
  end
  if (sign) begin
    r.z             = 32'h7fc0_0000;
    r.flags.invalid = 1'b1;
    return r;
  end
  if (e == 8'hff) begin
    r.z = a;
    return r;
  end

  r.uses_core = 1'b1;
  if (e != 0) begin
    m  = {2'b01, f};
    ue = int'(e) - 127;
  end else begin
    m  = {2'b00, f};
    ue = -126;
  end
  while (!m[23]) begin
    m  = m << 1;
    ue = ue - 1;
  end
  if (ue % 2 != 0) begin   // make the exponent even
    m  = m << 1;
    ue = ue - 1;
  end

  // value = n * 2^(ue-50), so sqrt = isqrt(n) * 2^(ue/2-25)
  n  = 64'(m) << 27;
  lo = 64'd0;
  hi = 64'd1 << 26;
  while (hi - lo > 1) begin
    mid = (lo + hi) >> 1;
    if (mid * mid <= n) lo = mid;
    else hi = mid;
  end
  rt  = lo[25:0];
  rem = n - lo * lo;

  sig   = rt[25:2];
  g     = rt[1];
  rb    = rt[0];
  s     = (rem != 0);
  above = g && (rb || s);    // beyond halfway
  tie   = g && !rb && !s;
  mode  = (rm > 3'd4) ? 3'd0 : rm;
  case (mode)
    3'd0:    up = above || (tie && sig[0]);
    3'd3:    up = g || rb || s;
    3'd4:    up = above || tie;
    default: up = 1'b0;      // toward zero and down, positive result
  endcase

  sig_r = {1'b0, sig} + 25'(up);
  be    = ue / 2 + 127;
  if (sig_r[24]) begin
    be    = be + 1;
    sig_r = sig_r >> 1;
  end
  r.z             = {1'b0, be[7:0], sig_r[22:0]};
  r.flags.inexact = g || rb || s;
  return r;
endfunction

`endif

//--- sim/tb_fsqrt.sv
/* testbench for the single-precision square root
   directed and random operands in every mode, checked against a reference model */
`default_nettype none

module tb_fsqrt import fsqrt_pkg::*; ();

  `include "fsqrt_ref.svh"

  typedef struct packed {
    logic [31:0] a;
    logic [2:0]  rm;
    logic        exact;       // operand is a perfect square
    logic [31:0] sample_cyc;  // edge that took in_stb
  } op_rec_t;

  // specials, exact squares, random, denormals, reserved modes, busy pokes
  localparam int n_ops           = 11 + 12 * 5 + 30 * 5 + 12 * 5 + 8 * 4 + 4;
  localparam int timeout_cycles  = n_ops * 40 + 200;
  localparam int core_latency    = 29;
  localparam int special_latency = 2;

  logic        clk     = 1'b0;
  logic        rst     = 1'b1;
  logic        in_stb  = 1'b0;
  logic [31:0] input_a = '0;
  logic [2:0]  frm     = '0;
  logic        busy;
  logic [31:0] output_z;
  logic        output_z_stb;
  flag_t       fflags;

  op_rec_t     pending[$];
  int          cyc        = 0;
  logic [31:0] last_rtz_a = 32'hffff_ffff;   // never a sent operand
  logic [31:0] last_rtz_z = '0;
  logic [31:0] last_rne_a = 32'hffff_ffff;
  logic [31:0] last_rne_z = '0;

  fsqrt i_fsqrt (
    .clk          (clk),
    .rst          (rst),
    .in_stb       (in_stb),
    .input_a      (input_a),
    .frm          (frm),
    .busy         (busy),
    .output_z     (output_z),
    .output_z_stb (output_z_stb),
    .fflags       (fflags)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= timeout_cycles) begin
      $display("timeout: run exceeded %0d cycles", timeout_cycles);
      $display("TB FAILED");
      $fatal(1, "run did not complete");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, want);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] int_to_float(input logic [31:0] v);
    int          msb;
    logic [31:0] sh;
    msb = 0;
    for (int i = 0; i < 32; i++) begin
      if (v[i]) msb = i;
    end
    sh = v << (23 - msb);    // v below 2^24, exact
    return {1'b0, 8'(127 + msb), sh[22:0]};
  endfunction

  function automatic logic [31:0] special_operand(input int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'h8000_0000;
      2:       return 32'h7f80_0000;   // +inf
      3:       return 32'hff80_0000;
      4:       return 32'h7fc0_0000;
      5:       return 32'h7f80_0001;   // signalling nan
      6:       return 32'hffc1_2345;
      7:       return 32'hbf80_0000;
      8:       return 32'hc049_0fdb;
      9:       return 32'h8000_0001;   // negative denormals
      default: return 32'h807f_ffff;
    endcase
  endfunction

  // odd and even unbiased exponents after normalising
  function automatic logic [31:0] denorm_operand(input int i);
    case (i)
      0:       return 32'h0000_0001;
      1:       return 32'h0000_0002;
      2:       return 32'h0000_0003;
      3:       return 32'h007f_ffff;
      4:       return 32'h0040_0000;
      default: return 32'h0020_0001;
    endcase
  endfunction

  function automatic logic [31:0] random_normal();
    return {1'b0, 8'(($urandom % 254) + 1), 23'($urandom)};
  endfunction

  // called right after a rising edge
  task automatic send_op(input logic [31:0] a, input logic [2:0] rm, input logic exact);
    op_rec_t rec;
    while (busy) @(posedge clk);
    in_stb  <= 1'b1;
    input_a <= a;
    frm     <= rm;
    rec.a          = a;
    rec.rm         = rm;
    rec.exact      = exact;
    rec.sample_cyc = cyc + 1;
    pending.push_back(rec);
    @(posedge clk);
    in_stb <= 1'b0;
    @(posedge clk);
  endtask

  // second strobe lands while the first operation runs and must be dropped
  task automatic send_with_poke(input logic [31:0] a, input logic [2:0] rm);
    send_op(a, rm, 1'b0);
    in_stb  <= 1'b1;
    input_a <= 32'h4049_0fdb;
    frm     <= rm_rup;
    @(posedge clk);
    check_value("busy", busy, 32'd1);
    in_stb <= 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] k;
    void'($urandom(32'hdea0));
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    for (int i = 0; i < 11; i++) send_op(special_operand(i), 3'(i % 5), 1'b0);

    for (int rm = 0; rm < 5; rm++) begin
      send_op(32'h3f80_0000, 3'(rm), 1'b1);   // 1.0
      send_op(32'h4080_0000, 3'(rm), 1'b1);   // 4.0
      send_op(32'h3e80_0000, 3'(rm), 1'b1);   // 0.25
      send_op(32'h7e80_0000, 3'(rm), 1'b1);   // 2^126
    end
    for (int i = 0; i < 8; i++) begin
      k = ($urandom % 4095) + 1;
      a = int_to_float(k * k);
      for (int rm = 0; rm < 5; rm++) send_op(a, 3'(rm), 1'b1);
    end

    // mode order puts rtz ahead of rdn and rup
    for (int i = 0; i < 30; i++) begin
      a = random_normal();
      for (int rm = 0; rm < 5; rm++) send_op(a, 3'(rm), 1'b0);
    end

    for (int i = 0; i < 12; i++) begin
      a = (i < 6) ? denorm_operand(i) : {9'b0, 23'(($urandom % 32'h7f_fffe) + 1)};
      for (int rm = 0; rm < 5; rm++) send_op(a, 3'(rm), 1'b0);
    end

    for (int i = 0; i < 8; i++) begin
      a = random_normal();
      send_op(a, rm_rne, 1'b0);
      for (int rm = 5; rm < 8; rm++) send_op(a, 3'(rm), 1'b0);
    end

    for (int i = 0; i < 4; i++) send_with_poke(random_normal(), 3'(i));

    while (pending.size() != 0) @(posedge clk);
    repeat (40) @(posedge clk);   // room for a stray strobe
    $display("TB PASSED");
    $finish;
  end

  always @(posedge clk) begin : compare
    op_rec_t     rec;
    ref_result_t want;
    logic [31:0] lat;
    if (output_z_stb) begin
      if (pending.size() == 0) begin
        $display("result strobe at time %0t with no operation pending", $time);
        $display("TB FAILED");
        $fatal(1, "unexpected result strobe");
      end else begin
        rec  = pending.pop_front();
        want = fsqrt_ref(rec.a, rec.rm);
        lat  = cyc - 1 - rec.sample_cyc;   // strobe was set one edge back
        check_value("output_z", output_z, want.z);
        check_value("fflags.invalid", 32'(fflags.invalid), 32'(want.flags.invalid));
        check_value("fflags.inexact", 32'(fflags.inexact), 32'(want.flags.inexact));
        check_value("latency", lat, want.uses_core ? core_latency : special_latency);
        check_value("busy in strobe cycle", 32'(busy), 32'd0);
        if (rec.exact) check_value("fflags.inexact on square", 32'(fflags.inexact), 32'd0);
        if (rec.rm == rm_rtz) begin
          last_rtz_a = rec.a;
          last_rtz_z = output_z;
        end
        if (rec.rm == rm_rdn && rec.a == last_rtz_a) begin
          check_value("output_z rdn vs rtz", output_z, last_rtz_z);
        end
        if (rec.rm == rm_rup && rec.a == last_rtz_a) begin
          check_value("output_z rup not below rtz", 32'(output_z >= last_rtz_z), 32'd1);
        end
        if (rec.rm == rm_rne) begin
          last_rne_a = rec.a;
          last_rne_z = output_z;
        end
        if (rec.rm > rm_rmm && rec.a == last_rne_a) begin
          check_value("output_z reserved mode vs rne", output_z, last_rne_z);
        end
      end
    end
  end

endmodule

`default_nettype wire
